/* flist.f */
verilog/ppu_pkg.sv
verilog/ppu_pixel_gearbox.sv
verilog/ppu_vram.sv
verilog/ppu_bg_layer.sv
verilog/ppu_bg_top.sv
testbench/bg_checker.sv
testbench/tb_ppu_bg.sv

/* run.sh */
#!/bin/sh
# Build and run the background layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_ppu_bg -o sim_tb_ppu_bg

./obj_dir/sim_tb_ppu_bg | tee sim.log

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
exit 0

/* testbench/bg_checker.sv */
/* Background layer checker
   Mirrors video memory, predicts each accepted pixel and reports per test */

`timescale 1ns/1ps

module bg_checker #(
	parameter int W_COORD    = ppu_pkg::W_COORD,
	parameter int VRAM_WORDS = 4096
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          en,
	input  logic                          flush,
	input  logic [W_COORD-1:0]            beam_x,
	input  logic [W_COORD-1:0]            beam_y,
	input  ppu_pkg::bg_cfg_t              cfg,
	input  logic                          host_wr_en,
	input  logic [$clog2(VRAM_WORDS)-1:0] host_wr_addr,
	input  logic [31:0]                   host_wr_data,
	input  logic                          out_valid,
	input  logic                          out_ready,
	input  ppu_pkg::pix_out_t             out_pix,
	output int                            pix_count,
	output int                            err_total
);

	import ppu_pkg::*;

	localparam int MEM_BYTES = VRAM_WORDS * 4;

	// Byte image of video memory, little-endian words
	logic [7:0]         mirror [MEM_BYTES];
	logic [W_COORD-1:0] x;
	logic [W_COORD-1:0] y;
	int                 fill_checks;
	int                 tests_run;
	int                 tests_bad;
	int                 mark_pix;
	int                 mark_err;
	int                 mark_fill;

	initial begin
		pix_count = 0;
		err_total = 0;
		fill_checks = 0;
		tests_run = 0;
		tests_bad = 0;
		mark_pix = 0;
		mark_err = 0;
		mark_fill = 0;
	end

	// ------------------------------
	// Reference pixel model

	function automatic pix_out_t ref_pixel(input bg_cfg_t c, input int px, input int py);
		int          wm;
		int          hm;
		int          u;
		int          v;
		int          tlog;
		int          ts;
		int          ltw;
		int          lbpp;
		int          map_idx;
		int          tile;
		int          set_idx;
		int          bit_idx;
		int          wa;
		int          raw;
		int          idx;
		logic [31:0] word;
		logic        pal;
		pix_out_t    p;
		wm = (int'(c.log_w) >= 8) ? 511 : (2 << int'(c.log_w)) - 1;
		hm = (int'(c.log_h) >= 8) ? 511 : (2 << int'(c.log_h)) - 1;
		u = (px + int'(c.scroll_x)) & wm;
		v = (py + int'(c.scroll_y)) & hm;
		tlog = c.tile_size ? 4 : 3;
		ts = 1 << tlog;
		case (c.pixel_mode)
			PAL1:    lbpp = 0;
			PAL2:    lbpp = 1;
			PAL4:    lbpp = 2;
			PAL8:    lbpp = 3;
			default: lbpp = 4;
		endcase
		pal = (c.pixel_mode != ARGB1555);
		// Tilemap is one byte per tile, row major
		ltw = int'(c.log_w) + 1 - tlog;
		map_idx = ((u >> tlog) | ((v >> tlog) << ltw)) & 32'hffff;
		tile = int'(mirror[(int'(c.tilemap_base) + map_idx) & 32'hffff & (MEM_BYTES - 1)]);
		set_idx = tile * ts * ts + (v & (ts - 1)) * ts + (u & (ts - 1));
		bit_idx = set_idx << lbpp;
		// Word aligned fetch, then the pixel sits at the low bits of the offset
		wa = (int'(c.tileset_base) + (bit_idx >> 3)) & 32'hfffc & (MEM_BYTES - 1);
		word = {mirror[wa + 3], mirror[wa + 2], mirror[wa + 1], mirror[wa]};
		raw = int'(word >> (bit_idx & 31)) & 32'hffff;
		idx = raw & ((1 << (1 << lbpp)) - 1);
		if (pal) begin
			p.pixdata = 15'(idx | ((lbpp < 3) ? (int'(c.palette_offset) << 4) : 0));
			p.alpha = !c.transparency || (idx != 0);
		end else begin
			p.pixdata = 15'(raw & 32'h7fff);
			p.alpha = !c.transparency || ((raw & 32'h8000) != 0);
		end
		return p;
	endfunction

	// ------------------------------
	// Capture and compare

	always @(posedge clk) begin
		pix_out_t exp_p;
		if (rst_n) begin
			if (host_wr_en) begin
				mirror[{host_wr_addr, 2'd0}] <= host_wr_data[7:0];
				mirror[{host_wr_addr, 2'd1}] <= host_wr_data[15:8];
				mirror[{host_wr_addr, 2'd2}] <= host_wr_data[23:16];
				mirror[{host_wr_addr, 2'd3}] <= host_wr_data[31:24];
			end
			if (!en) begin
				// Disabled layer must stream transparent black
				if (!out_valid || out_pix != '0) begin
					$display("ERROR %0t: disabled output valid=%0b pix=%h, expected valid fill 0",
						$time, out_valid, out_pix);
					err_total <= err_total + 1;
				end
				fill_checks <= fill_checks + 1;
			end else if (flush) begin
				x <= beam_x;
				y <= beam_y;
			end else if (out_valid && out_ready) begin
				exp_p = ref_pixel(cfg, int'(x), int'(y));
				if (out_pix !== exp_p) begin
					$display("ERROR %0t: x=%0d y=%0d expected %0b/%h got %0b/%h", $time, x, y,
						exp_p.alpha, exp_p.pixdata, out_pix.alpha, out_pix.pixdata);
					err_total <= err_total + 1;
				end
				x <= x + 1'b1;
				pix_count <= pix_count + 1;
			end
		end
	end

	// ------------------------------
	// Reporting

	task automatic end_test(input string name);
		int errs;
		errs = err_total - mark_err;
		tests_run = tests_run + 1;
		if (errs != 0)
			tests_bad = tests_bad + 1;
		$display("Test %0d %s: %0d pixels, %0d fill cycles, %0d errors, %s", tests_run, name,
			pix_count - mark_pix, fill_checks - mark_fill, errs, (errs == 0) ? "ok" : "MISMATCH");
		mark_pix = pix_count;
		mark_err = err_total;
		mark_fill = fill_checks;
	endtask

	task automatic print_summary();
		$display("Summary: %0d tests, %0d with errors, %0d pixels, %0d fill cycles, %0d errors",
			tests_run, tests_bad, pix_count, fill_checks, err_total);
	endtask

endmodule

/* testbench/tb_ppu_bg.sv */
/* Background layer testbench
   Loads video memory, runs scanlines under several configurations */

`timescale 1ns/1ps

module tb_ppu_bg;

	import ppu_pkg::*;

	localparam int VRAM_WORDS = 4096;
	// Pixels and fill cycles over all tests
	localparam int TOTAL_PIX = 770;
	localparam int CYCLE_LIMIT = TOTAL_PIX * 40 + 2000;

	logic               clk;
	logic               rst_n;
	logic               en;
	logic               flush;
	logic [W_COORD-1:0] beam_x;
	logic [W_COORD-1:0] beam_y;
	bg_cfg_t            cfg;
	logic               host_wr_en;
	logic [11:0]        host_wr_addr;
	logic [31:0]        host_wr_data;
	logic               out_ready;
	logic               out_valid;
	pix_out_t           out_pix;
	int                 pix_count;
	int                 err_total;
	logic [31:0]        lfsr_state;
	logic               running;
	int                 cycles;
	logic               random_ready;
	logic               host_noise;
	pixel_mode_e        modes [5];

	ppu_bg_top #(
		.W_COORD    (W_COORD),
		.W_ADDR     (W_ADDR),
		.W_DATA     (W_DATA),
		.VRAM_WORDS (VRAM_WORDS)
	) DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.en           (en),
		.flush        (flush),
		.beam_x       (beam_x),
		.beam_y       (beam_y),
		.cfg          (cfg),
		.host_wr_en   (host_wr_en),
		.host_wr_addr (host_wr_addr),
		.host_wr_data (host_wr_data),
		.out_ready    (out_ready),
		.out_valid    (out_valid),
		.out_pix      (out_pix)
	);

	bg_checker #(
		.W_COORD    (W_COORD),
		.VRAM_WORDS (VRAM_WORDS)
	) chk (
		.clk          (clk),
		.rst_n        (rst_n),
		.en           (en),
		.flush        (flush),
		.beam_x       (beam_x),
		.beam_y       (beam_y),
		.cfg          (cfg),
		.host_wr_en   (host_wr_en),
		.host_wr_addr (host_wr_addr),
		.host_wr_data (host_wr_data),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_pix      (out_pix),
		.pix_count    (pix_count),
		.err_total    (err_total)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// Run limit counts only the cycles of the tests
	always @(posedge clk) begin
		if (running) begin
			cycles <= cycles + 1;
			if (cycles >= CYCLE_LIMIT) begin
				$display("Timeout: the run reached the limit of %0d cycles", CYCLE_LIMIT);
				$display("Testbench failed");
				$finish;
			end
		end
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'ha300_0000) : (lfsr_state >> 1);
		end
		return r;
	endfunction

	function automatic bg_cfg_t make_cfg(input logic [8:0] sx, input logic [8:0] sy,
		input logic big, input pixel_mode_e m, input logic tr, input logic [3:0] off,
		input logic [15:0] set_base, input logic [15:0] map_base);
		bg_cfg_t c;
		c.scroll_x = sx;
		c.scroll_y = sy;
		// 256 x 256 playfield
		c.log_w = 4'd7;
		c.log_h = 4'd7;
		c.tileset_base = set_base;
		c.tilemap_base = map_base;
		c.tile_size = big;
		c.pixel_mode = m;
		c.transparency = tr;
		c.palette_offset = off;
		return c;
	endfunction

	// ------------------------------
	// Stimulus tasks enter and leave 1 ns after an edge

	task automatic start_line(input bg_cfg_t c, input logic [8:0] bx, input logic [8:0] by);
		out_ready = 1'b0;
		cfg = c;
		beam_x = bx;
		beam_y = by;
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
	endtask

	task automatic wait_pixels(input int n);
		int          target;
		logic [31:0] r;
		target = pix_count + n;
		while (pix_count < target) begin
			r = take_bits(1);
			out_ready = random_ready ? r[0] : 1'b1;
			host_wr_en = 1'b0;
			// Writes land in the top quarter, away from this test's tiles and map
			if (host_noise) begin
				r = take_bits(2);
				if (r[1:0] == 2'd0) begin
					host_wr_en = 1'b1;
					host_wr_addr = 12'(3072 + take_bits(10));
					host_wr_data = take_bits(32);
				end
			end
			@(posedge clk);
			#1;
		end
		host_wr_en = 1'b0;
	endtask

	task automatic fill_cycles(input int n);
		logic [31:0] r;
		repeat (n) begin
			r = take_bits(1);
			out_ready = r[0];
			@(posedge clk);
			#1;
		end
	endtask

	// ------------------------------
	// Test sequence

	initial begin
		lfsr_state = 32'h6808d98c;
		modes = '{PAL1, PAL2, PAL4, PAL8, ARGB1555};
		rst_n = 1'b0;
		en = 1'b0;
		flush = 1'b0;
		beam_x = '0;
		beam_y = '0;
		cfg = '0;
		host_wr_en = 1'b0;
		host_wr_addr = '0;
		host_wr_data = '0;
		out_ready = 1'b0;
		running = 1'b0;
		cycles = 0;
		random_ready = 1'b0;
		host_noise = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Whole memory filled from the LFSR
		// The checker mirrors each write
		for (int w = 0; w < VRAM_WORDS; w++) begin
			host_wr_en = 1'b1;
			host_wr_addr = 12'(w);
			host_wr_data = take_bits(32);
			@(posedge clk);
			#1;
		end
		host_wr_en = 1'b0;
		running = 1'b1;

		en = 1'b1;
		start_line(make_cfg(9'd0, 9'd0, 1'b0, PAL4, 1'b0, 4'h5, 16'h0000, 16'h2000), 9'd0, 9'd0);
		wait_pixels(64);
		chk.end_test("pal4 8x8 no scroll");

		for (int m = 0; m < 5; m++) begin
			start_line(make_cfg(9'd0, 9'd0, 1'b1, modes[m], 1'b1, 4'(m + 9), 16'h0000, 16'h3000),
				9'(3 * m), 9'(20 + 7 * m));
			wait_pixels(48);
		end
		chk.end_test("all modes 16x16 transparent");

		start_line(make_cfg(9'd203, 9'd37, 1'b0, PAL4, 1'b0, 4'h3, 16'h0000, 16'h2000), 9'd10, 9'd5);
		wait_pixels(80);
		start_line(make_cfg(9'd250, 9'd300, 1'b1, PAL2, 1'b1, 4'h6, 16'h0000, 16'h3000), 9'd0, 9'd9);
		wait_pixels(80);
		chk.end_test("scroll and wrap");

		random_ready = 1'b1;
		host_noise = 1'b1;
		start_line(make_cfg(9'd5, 9'd3, 1'b0, PAL4, 1'b0, 4'ha, 16'h0000, 16'h2000), 9'd0, 9'd12);
		wait_pixels(128);
		random_ready = 1'b0;
		host_noise = 1'b0;
		chk.end_test("back-pressure and host writes");

		start_line(make_cfg(9'd17, 9'd0, 1'b0, PAL8, 1'b0, 4'h0, 16'h0000, 16'h2000), 9'd0, 9'd50);
		wait_pixels(20);
		out_ready = 1'b1;
		// Flush while a read is being accepted
		while (!(DUT.req_valid && DUT.req_ready)) begin
			@(posedge clk);
			#1;
		end
		start_line(make_cfg(9'd17, 9'd0, 1'b0, PAL8, 1'b0, 4'h0, 16'h0000, 16'h2000), 9'd7, 9'd51);
		wait_pixels(64);
		chk.end_test("flush mid-line");

		en = 1'b0;
		fill_cycles(30);
		en = 1'b1;
		start_line(make_cfg(9'd33, 9'd2, 1'b1, ARGB1555, 1'b1, 4'h0, 16'h0000, 16'h3000),
			9'd4, 9'd60);
		wait_pixels(64);
		chk.end_test("disable and resume");

		chk.print_summary();
		if (err_total == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* verilog/ppu_bg_layer.sv */
/* Tiled background layer
   Fetches tiles and pixel words from video memory, streams one pixel per handshake */

`timescale 1ns/1ps

module ppu_bg_layer #(
	parameter int W_COORD = ppu_pkg::W_COORD,
	parameter int W_ADDR  = ppu_pkg::W_ADDR,
	parameter int W_DATA  = ppu_pkg::W_DATA
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               en,
	input  logic               flush,
	input  logic [W_COORD-1:0] beam_x,
	input  logic [W_COORD-1:0] beam_y,
	input  ppu_pkg::bg_cfg_t   cfg,
	output logic               req_valid,
	output ppu_pkg::vram_req_t req,
	input  logic               req_ready,
	input  logic               rsp_valid,
	input  logic [W_DATA-1:0]  rsp_data,
	output logic               out_valid,
	output ppu_pkg::pix_out_t  out_pix,
	input  logic               out_ready
);

	import ppu_pkg::*;

	logic [W_COORD-1:0] u, v;
	logic [W_COORD:0]   w_span, h_span;
	logic [W_COORD-1:0] w_mask, h_mask, u_flush, v_flush;
	logic [2:0]         log_bpp, tile_log;
	logic [3:0]         tile_last, pixctr, log_tiles_w;
	logic               tile_empty, word_live, pix_wait, dirty;
	logic [7:0]         tile;
	logic               gb_empty, gb_load, pix_avail, out_fire, tile_edge;
	logic [15:0]        gb_pix;
	logic               fire, need_pix, rsp_ok;
	logic               rsp_tile;
	logic [1:0]         rsp_byte;
	logic [4:0]         rsp_skip, pix_skip;
	logic [W_DATA-1:0]  tile_word;
	logic [W_ADDR-1:0]  map_idx, tile_addr, pix_addr;
	logic [15:0]        set_idx;
	logic [19:0]        bit_idx;
	logic [7:0]         pal_mask, pal_idx, pal_val;
	logic               paletted, pix_alpha;

	// ------------------------------
	// Coordinates

	// Playfield masks, 2**(log+1) pixels wide and high
	assign w_span = ~({{W_COORD{1'b1}}, 1'b0} << cfg.log_w);
	assign h_span = ~({{W_COORD{1'b1}}, 1'b0} << cfg.log_h);
	assign w_mask = w_span[W_COORD-1:0];
	assign h_mask = h_span[W_COORD-1:0];
	assign u_flush = (beam_x + cfg.scroll_x) & w_mask;
	assign v_flush = (beam_y + cfg.scroll_y) & h_mask;

	assign log_bpp = mode_log_bpp(cfg.pixel_mode);
	assign tile_log = cfg.tile_size ? 3'd4 : 3'd3;
	assign tile_last = {cfg.tile_size, 3'b111};

	// A pixel is ready once the current tile's word is past its skip
	assign pix_avail = word_live && !gb_empty && !tile_empty;
	// Disabled layer keeps the stream moving with transparent fill
	assign out_valid = !en || (pix_avail && !flush);
	assign out_fire = en && out_valid && out_ready;
	assign tile_edge = out_fire && (pixctr == tile_last);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			u <= '0;
			v <= '0;
		end else if (flush) begin
			u <= u_flush;
			v <= v_flush;
		end else if (out_fire) begin
			u <= (u + 1'b1) & w_mask;
		end
	end

	// ------------------------------
	// Tile bookkeeping

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tile_empty <= 1'b1;
			pixctr <= 4'd0;
		end else if (flush) begin
			tile_empty <= 1'b1;
			pixctr <= u_flush[3:0] & tile_last;
		end else if (tile_empty) begin
			if (rsp_ok && rsp_tile)
				tile_empty <= 1'b0;
		end else if (tile_edge) begin
			// Playfield wrap always lands on a tile edge too
			tile_empty <= 1'b1;
			pixctr <= 4'd0;
		end else if (out_fire) begin
			pixctr <= pixctr + 4'd1;
		end
	end

	// Tile number byte picked from the little-endian word
	assign tile_word = rsp_data >> {rsp_byte, 3'b000};

	always_ff @(posedge clk) begin
		if (rsp_ok && rsp_tile)
			tile <= tile_word[7:0];
	end

	// ------------------------------
	// Address generation

	// One tilemap byte per tile, rows of 2**log_tiles_w tiles
	assign log_tiles_w = cfg.log_w + 4'd1 - {1'b0, tile_log};
	assign map_idx = W_ADDR'(u >> tile_log) | (W_ADDR'(v >> tile_log) << log_tiles_w);
	assign tile_addr = cfg.tilemap_base + map_idx;

	// Pixel index inside the tileset, then scaled to a bit index
	assign set_idx = cfg.tile_size ? {tile, v[3:0], u[3:0]} : {2'b00, tile, v[2:0], u[2:0]};
	assign bit_idx = {4'd0, set_idx} << log_bpp;
	assign pix_addr = (cfg.tileset_base + W_ADDR'(bit_idx[19:3])) & ~W_ADDR'(3);
	// Leading pixels in the word ahead of the one we want
	assign pix_skip = 5'(bit_idx[4:0] >> log_bpp);

	// ------------------------------
	// Bus control

	// New word needed after a tile edge, or when the gearbox ran dry
	assign need_pix = !tile_empty && !pix_wait && (!word_live || gb_empty);
	// Tile fetch first, nothing while a response is due this cycle
	assign req_valid = en && !rsp_valid && (tile_empty || need_pix);
	assign req.addr = tile_empty ? tile_addr : pix_addr;
	assign fire = req_valid && req_ready;

	// Flush drops whatever lands in its own cycle or the next
	assign rsp_ok = rsp_valid && !dirty && !flush;
	assign gb_load = rsp_ok && !rsp_tile;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dirty <= 1'b0;
			pix_wait <= 1'b0;
			word_live <= 1'b0;
		end else begin
			// Read accepted alongside a flush is stale
			dirty <= flush && fire;
			if (flush)
				pix_wait <= 1'b0;
			else if (fire && !tile_empty)
				pix_wait <= 1'b1;
			else if (word_live && !gb_empty)
				pix_wait <= 1'b0;
			if (flush || tile_edge)
				word_live <= 1'b0;
			else if (gb_load)
				word_live <= 1'b1;
		end
	end

	// Data phase info for the read in flight
	always_ff @(posedge clk) begin
		if (fire) begin
			rsp_tile <= tile_empty;
			rsp_byte <= req.addr[1:0];
			rsp_skip <= pix_skip;
		end
	end

	ppu_pixel_gearbox #(
		.W_DATA (W_DATA)
	) gearbox_u (
		.clk     (clk),
		.rst_n   (rst_n),
		.load    (gb_load),
		.din     (rsp_data),
		.log_bpp (log_bpp),
		.skip    (rsp_skip),
		.shift   (out_fire),
		.empty   (gb_empty),
		.pix     (gb_pix)
	);

	// ------------------------------
	// Pixel formatting

	always_comb begin
		case (log_bpp)
			3'd0:    pal_mask = 8'h01;
			3'd1:    pal_mask = 8'h03;
			3'd2:    pal_mask = 8'h0f;
			default: pal_mask = 8'hff;
		endcase
	end

	assign paletted = mode_is_paletted(cfg.pixel_mode);
	assign pal_idx = gb_pix[7:0] & pal_mask;
	// Offset selects a 16-entry bank for the narrow modes
	assign pal_val = pal_idx | (log_bpp < 3'd3 ? {cfg.palette_offset, 4'h0} : 8'h00);
	assign pix_alpha = paletted ? |pal_idx : gb_pix[15];

	always_comb begin
		out_pix.alpha = en && (!cfg.transparency || pix_alpha);
		if (!en)
			out_pix.pixdata = 15'd0;
		else if (paletted)
			out_pix.pixdata = {7'd0, pal_val};
		else
			out_pix.pixdata = gb_pix[14:0];
	end

endmodule

/* verilog/ppu_bg_top.sv */
/* Background layer top level
   Tiled layer and its video memory, with the host write port */

`timescale 1ns/1ps

module ppu_bg_top #(
	parameter int W_COORD    = ppu_pkg::W_COORD,
	parameter int W_ADDR     = ppu_pkg::W_ADDR,
	parameter int W_DATA     = ppu_pkg::W_DATA,
	parameter int VRAM_WORDS = 4096
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          en,
	input  logic                          flush,
	input  logic [W_COORD-1:0]            beam_x,
	input  logic [W_COORD-1:0]            beam_y,
	input  ppu_pkg::bg_cfg_t              cfg,
	input  logic                          host_wr_en,
	input  logic [$clog2(VRAM_WORDS)-1:0] host_wr_addr,
	input  logic [W_DATA-1:0]             host_wr_data,
	input  logic                          out_ready,
	output logic                          out_valid,
	output ppu_pkg::pix_out_t             out_pix
);

	// Layer to memory read bus
	logic               req_valid;
	ppu_pkg::vram_req_t req;
	logic               req_ready;
	logic               rsp_valid;
	logic [W_DATA-1:0]  rsp_data;

	ppu_bg_layer #(
		.W_COORD (W_COORD),
		.W_ADDR  (W_ADDR),
		.W_DATA  (W_DATA)
	) layer_u (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (en),
		.flush     (flush),
		.beam_x    (beam_x),
		.beam_y    (beam_y),
		.cfg       (cfg),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.out_valid (out_valid),
		.out_pix   (out_pix),
		.out_ready (out_ready)
	);

	ppu_vram #(
		.W_ADDR     (W_ADDR),
		.W_DATA     (W_DATA),
		.VRAM_WORDS (VRAM_WORDS)
	) vram_u (
		.clk          (clk),
		.rst_n        (rst_n),
		.host_wr_en   (host_wr_en),
		.host_wr_addr (host_wr_addr),
		.host_wr_data (host_wr_data),
		.req_valid    (req_valid),
		.req          (req),
		.req_ready    (req_ready),
		.rsp_valid    (rsp_valid),
		.rsp_data     (rsp_data)
	);

endmodule

/* verilog/ppu_pixel_gearbox.sv */
/* Pixel gearbox
   Unpacks one bus word into pixels of 1 to 16 bits, with a leading skip */

`timescale 1ns/1ps

module ppu_pixel_gearbox #(
	parameter int W_DATA = ppu_pkg::W_DATA
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              load,
	input  logic [W_DATA-1:0] din,
	input  logic [2:0]        log_bpp,
	input  logic [4:0]        skip,
	input  logic              shift,
	output logic              empty,
	output logic [15:0]       pix
);

	// Enough bits to hold the full word size itself
	localparam int W_CNT = $clog2(W_DATA) + 1;

	logic [W_DATA-1:0] sreg;
	logic [W_CNT-1:0]  bits_left;
	logic [4:0]        skip_left;
	logic [W_CNT-1:0]  pix_bits;
	logic              advance;

	assign pix_bits = W_CNT'(1) << log_bpp;

	// Skipped pixels drain on their own, real pixels wait for shift
	assign advance = (skip_left != 5'd0) || (shift && bits_left != '0);

	// ------------------------------
	// Fill and skip counters

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bits_left <= '0;
			skip_left <= 5'd0;
		end else if (load) begin
			bits_left <= W_CNT'(W_DATA);
			skip_left <= skip;
		end else if (advance) begin
			bits_left <= bits_left - pix_bits;
			if (skip_left != 5'd0)
				skip_left <= skip_left - 5'd1;
		end
	end

	// Data word, lowest bits are the next pixel
	always_ff @(posedge clk) begin
		if (load)
			sreg <= din;
		else if (advance)
			sreg <= sreg >> pix_bits;
	end

	// No pixel to show while skipping or once the word is used up
	assign empty = (bits_left == '0) || (skip_left != 5'd0);
	assign pix = sreg[15:0];

endmodule

/* verilog/ppu_pkg.sv */
/* PPU shared definitions
   Layer configuration, pixel and bus types, pixel mode helpers */

package ppu_pkg;

	// Default widths, passed down as module parameters from the top level
	localparam int W_COORD = 9;
	localparam int W_ADDR  = 16;
	localparam int W_DATA  = 32;

	typedef enum logic [2:0] {
		PAL1     = 3'd0,
		PAL2     = 3'd1,
		PAL4     = 3'd2,
		PAL8     = 3'd3,
		ARGB1555 = 3'd4
	} pixel_mode_e;

	// Background layer configuration, static during a scanline
	typedef struct packed {
		logic [W_COORD-1:0] scroll_x;
		logic [W_COORD-1:0] scroll_y;
		// Playfield is 2**(log+1) pixels on each axis
		logic [3:0]         log_w;
		logic [3:0]         log_h;
		logic [W_ADDR-1:0]  tileset_base;
		logic [W_ADDR-1:0]  tilemap_base;
		// Set for 16x16 tiles
		logic               tile_size;
		pixel_mode_e        pixel_mode;
		logic               transparency;
		logic [3:0]         palette_offset;
	} bg_cfg_t;

	typedef struct packed {
		logic        alpha;
		logic [14:0] pixdata;
	} pix_out_t;

	// Byte address of a video memory read
	typedef struct packed {
		logic [W_ADDR-1:0] addr;
	} vram_req_t;

	// log2 of bits per pixel
	function automatic logic [2:0] mode_log_bpp(pixel_mode_e mode);
		case (mode)
			PAL1:     return 3'd0;
			PAL2:     return 3'd1;
			PAL4:     return 3'd2;
			PAL8:     return 3'd3;
			ARGB1555: return 3'd4;
			default:  return 3'd0;
		endcase
	endfunction

	function automatic logic mode_is_paletted(pixel_mode_e mode);
		return mode inside {PAL1, PAL2, PAL4, PAL8};
	endfunction

endpackage

/* verilog/ppu_vram.sv */
/* Video memory
   Single-port word array, host writes win over layer reads */

`timescale 1ns/1ps

module ppu_vram #(
	parameter int W_ADDR     = ppu_pkg::W_ADDR,
	parameter int W_DATA     = ppu_pkg::W_DATA,
	parameter int VRAM_WORDS = 4096
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          host_wr_en,
	input  logic [$clog2(VRAM_WORDS)-1:0] host_wr_addr,
	input  logic [W_DATA-1:0]             host_wr_data,
	input  logic                          req_valid,
	input  ppu_pkg::vram_req_t            req,
	output logic                          req_ready,
	output logic                          rsp_valid,
	output logic [W_DATA-1:0]             rsp_data
);

	localparam int W_WADDR = $clog2(VRAM_WORDS);

	logic [W_DATA-1:0]  mem [VRAM_WORDS];
	logic [W_ADDR-1:0]  rd_addr;
	logic [W_WADDR-1:0] rd_idx;
	logic               rd_fire;

	// Byte address in, word index out
	assign rd_addr = req.addr;
	assign rd_idx = rd_addr[W_WADDR+1:2];

	// The one port is busy whenever the host writes
	assign req_ready = !host_wr_en;
	assign rd_fire = req_valid && req_ready;

	// ------------------------------
	// Array access

	always_ff @(posedge clk) begin
		if (host_wr_en)
			mem[host_wr_addr] <= host_wr_data;
		else if (rd_fire)
			rsp_data <= mem[rd_idx];
	end

	// Response strobe, exactly one cycle after the accepted read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= rd_fire;
	end

endmodule
